// File: design/river_geom_pkg.sv
package river_geom_pkg;

    // Screen coordinate in scan counts
    typedef logic [9:0] coord_t;

    // Lane index, 0 left to 2 right
    typedef logic [1:0] lane_t;

    typedef enum logic [1:0] {
        ST_START,
        ST_PLAY,
        ST_GAMEOVER
    } game_state_t;

    // Visible area starts this far into the line
    localparam coord_t H_VISIBLE_START = 10'd144;

    // Water spans 140 to 500 in screen pixels
    localparam coord_t SAND_LEFT  = H_VISIBLE_START + 10'd140;
    localparam coord_t SAND_RIGHT = H_VISIBLE_START + 10'd500;

    // Lane centres, index 0 is the left lane
    localparam coord_t [2:0] LANE_X_CENTER = {
        H_VISIBLE_START + 10'd460,
        H_VISIBLE_START + 10'd320,
        H_VISIBLE_START + 10'd180
    };

    // Boat rectangle, bottom row exclusive
    localparam coord_t BOAT_HALF_W   = 10'd32;
    localparam coord_t BOAT_Y_TOP    = 10'd400;
    localparam coord_t BOAT_Y_BOTTOM = 10'd480;

    // Rock rectangle
    localparam coord_t ROCK_HALF_W = 10'd32;
    localparam coord_t ROCK_HEIGHT = 10'd64;

    // Pixels per motion tick
    localparam coord_t BOAT_STEP = 10'd5;
    localparam coord_t ROCK_STEP = 10'd4;

    // Rows at or past this go back to the top
    localparam coord_t ROCK_WRAP_Y = 10'd559;

    // Rows treated as near the top when choosing a new lane
    localparam coord_t SPAWN_ZONE = 10'd100;

    localparam int ROCK_COUNT = 4;

    // Start layout, staggered 120 rows apart
    localparam coord_t [ROCK_COUNT-1:0] ROCK_START_Y    = {10'd360, 10'd240, 10'd120, 10'd0};
    localparam lane_t  [ROCK_COUNT-1:0] ROCK_START_LANE = {2'd0, 2'd1, 2'd2, 2'd0};

    localparam int SCORE_W = 16;

endpackage

// File: design/river_video_pkg.sv
package river_video_pkg;

    // 4 bits each of red, green, blue
    typedef logic [11:0] rgb_t;

    localparam rgb_t BLACK      = 12'h000;
    localparam rgb_t SAND       = 12'hECA;
    localparam rgb_t WATER      = 12'h468;
    localparam rgb_t ROCK_GRAY  = 12'h888;
    localparam rgb_t BOAT_WHITE = 12'hFFF;
    localparam rgb_t HIT_RED    = 12'hF00;

    // Current scan position
    typedef struct packed {
        river_geom_pkg::coord_t h;
        river_geom_pkg::coord_t v;
    } scan_t;

    // One drawing layer at the scanned pixel
    typedef struct packed {
        logic covered;
        rgb_t color;
    } layer_t;

endpackage

// File: design/boat_steer.sv
module boat_steer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    run,
    input  logic                    restart,
    input  logic                    tick,
    input  logic                    btn_left,
    input  logic                    btn_right,
    input  river_video_pkg::scan_t  scan,
    output river_video_pkg::layer_t boat_layer
);
    import river_geom_pkg::*;
    import river_video_pkg::*;

    typedef enum logic {
        BOAT_READY,
        BOAT_MOVING
    } boat_state_t;

    boat_state_t state;
    lane_t       lane;
    coord_t      boat_x;
    coord_t      target_x;
    logic        in_boat;

    // Centre of the lane the boat heads for
    assign target_x = LANE_X_CENTER[lane];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Middle lane, parked
            state  <= BOAT_READY;
            lane   <= 2'd1;
            boat_x <= LANE_X_CENTER[1];
        end else if (restart) begin
            state  <= BOAT_READY;
            lane   <= 2'd1;
            boat_x <= LANE_X_CENTER[1];
        end else if (run) begin
            case (state)
                BOAT_READY: begin
                    // Left wins when both are held
                    if (btn_left && lane != 2'd0) begin
                        lane  <= lane - 2'd1;
                        state <= BOAT_MOVING;
                    end else if (btn_right && lane != 2'd2) begin
                        lane  <= lane + 2'd1;
                        state <= BOAT_MOVING;
                    end
                end
                BOAT_MOVING: begin
                    // Arrived, take buttons again from next cycle
                    if (boat_x == target_x) begin
                        state <= BOAT_READY;
                    end else if (tick) begin
                        // Lane spacing is a multiple of the step, no overshoot
                        if (boat_x < target_x) begin
                            boat_x <= boat_x + BOAT_STEP;
                        end else begin
                            boat_x <= boat_x - BOAT_STEP;
                        end
                    end
                end
                default: state <= BOAT_READY;
            endcase
        end
    end

    // Solid rectangle around the boat centre
    assign in_boat = (scan.h >= boat_x - BOAT_HALF_W) && (scan.h < boat_x + BOAT_HALF_W) &&
                     (scan.v >= BOAT_Y_TOP) && (scan.v < BOAT_Y_BOTTOM);

    always_comb begin
        boat_layer.covered = in_boat;
        boat_layer.color   = BOAT_WHITE;
    end

    // Lane stays on the river
    a_lane_range : assert property (@(posedge clk) disable iff (!arst_n)
        lane <= 2'd2);

    // Sliding never leaves the span of the outer lanes
    a_x_range : assert property (@(posedge clk) disable iff (!arst_n)
        boat_x >= LANE_X_CENTER[0] && boat_x <= LANE_X_CENTER[2]);

endmodule

// File: design/rock_field.sv
module rock_field (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                run,
    input  logic                                restart,
    input  logic                                tick,
    input  river_video_pkg::scan_t              scan,
    output river_video_pkg::layer_t             rock_layer,
    output logic [river_geom_pkg::SCORE_W-1:0]  score
);
    import river_geom_pkg::*;
    import river_video_pkg::*;

    // LFSR start value and feedback taps, x^8 + x^6 + 1
    localparam logic [7:0] LFSR_SEED = 8'hAC;
    localparam int         TAP_HI    = 7;
    localparam int         TAP_LO    = 5;

    typedef struct packed {
        lane_t  lane;
        coord_t y;
    } rock_t;

    typedef rock_t [ROCK_COUNT-1:0] rock_set_t;

    rock_set_t               rocks;
    rock_set_t               rocks_next;
    logic [ROCK_COUNT-1:0]   wrap;
    lane_t [ROCK_COUNT-1:0]  spawn_lane;
    logic [7:0]              lfsr;
    logic                    in_rock;

    // Staggered start layout from the package tables
    function automatic rock_set_t start_set();
        rock_set_t s;
        for (int i = 0; i < ROCK_COUNT; i++) begin
            s[i].lane = ROCK_START_LANE[i];
            s[i].y    = ROCK_START_Y[i];
        end
        return s;
    endfunction

    // Lane choice and next position for every rock
    always_comb begin
        logic [2:0] busy;
        for (int i = 0; i < ROCK_COUNT; i++) begin
            wrap[i] = (rocks[i].y >= ROCK_WRAP_Y);
            // Lanes held near the top by the other rocks
            busy = '0;
            for (int j = 0; j < ROCK_COUNT; j++) begin
                if (j != i && rocks[j].y < SPAWN_ZONE) begin
                    busy[rocks[j].lane] = 1'b1;
                end
            end
            // All blocked, middle lane; else two LFSR bits per rock
            if (&busy) begin
                spawn_lane[i] = 2'd1;
            end else begin
                spawn_lane[i] = lfsr[2*i +: 2] % 2'd3;
            end
            if (wrap[i]) begin
                rocks_next[i].y    = '0;
                rocks_next[i].lane = spawn_lane[i];
            end else begin
                rocks_next[i].y    = rocks[i].y + ROCK_STEP;
                rocks_next[i].lane = rocks[i].lane;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rocks <= start_set();
            score <= '0;
        end else if (restart) begin
            rocks <= start_set();
            score <= '0;
        end else if (run && tick) begin
            rocks <= rocks_next;
            // One point per tick however many rocks wrap
            score <= score + SCORE_W'(|wrap);
        end
    end

    // Free running, only reloaded with the rest of the field
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr <= LFSR_SEED;
        end else if (restart) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[TAP_HI] ^ lfsr[TAP_LO]};
        end
    end

    // Scanned pixel inside any rock
    always_comb begin
        coord_t cx;
        in_rock = 1'b0;
        for (int i = 0; i < ROCK_COUNT; i++) begin
            cx = LANE_X_CENTER[rocks[i].lane];
            if (scan.h >= cx - ROCK_HALF_W && scan.h < cx + ROCK_HALF_W &&
                scan.v >= rocks[i].y && scan.v < rocks[i].y + ROCK_HEIGHT) begin
                in_rock = 1'b1;
            end
        end
    end

    always_comb begin
        rock_layer.covered = in_rock;
        rock_layer.color   = ROCK_GRAY;
    end

    // Spawn choice never produces lane 3
    a_rock_lanes : assert property (@(posedge clk) disable iff (!arst_n)
        rocks[0].lane <= 2'd2 && rocks[1].lane <= 2'd2 &&
        rocks[2].lane <= 2'd2 && rocks[3].lane <= 2'd2);

endmodule

// File: design/river_scene.sv
module river_scene (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    bright,
    input  logic                    btn_center,
    input  river_video_pkg::scan_t  scan,
    input  river_video_pkg::layer_t boat_layer,
    input  river_video_pkg::layer_t rock_layer,
    output logic                    run,
    output logic                    restart,
    output logic                    game_over,
    output river_video_pkg::rgb_t   rgb
);
    import river_geom_pkg::*;
    import river_video_pkg::*;

    game_state_t state;
    game_state_t state_next;
    logic        overlap;
    logic        in_sand;

    // Boat and rock both at the scanned pixel
    assign overlap = boat_layer.covered && rock_layer.covered;

    always_comb begin
        state_next = state;
        case (state)
            // Single cycle while the parts reload
            ST_START: state_next = ST_PLAY;
            ST_PLAY: begin
                // Restart beats a crash on the same cycle
                if (btn_center) begin
                    state_next = ST_START;
                end else if (overlap) begin
                    state_next = ST_GAMEOVER;
                end
            end
            ST_GAMEOVER: begin
                if (btn_center) begin
                    state_next = ST_START;
                end
            end
            default: state_next = ST_START;
        endcase
    end

    // Game begins in play straight out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_PLAY;
        end else begin
            state <= state_next;
        end
    end

    assign run       = (state == ST_PLAY);
    assign restart   = (state == ST_START);
    assign game_over = (state == ST_GAMEOVER);

    // Borders left and right of the water
    assign in_sand = (scan.h < SAND_LEFT) || (scan.h >= SAND_RIGHT);

    // Pixel colour with the highest priority first
    always_comb begin
        if (!bright) begin
            rgb = BLACK;
        end else if (game_over && overlap) begin
            rgb = HIT_RED;
        end else if (in_sand) begin
            rgb = SAND;
        end else if (boat_layer.covered) begin
            rgb = boat_layer.color;
        end else if (rock_layer.covered) begin
            rgb = rock_layer.color;
        end else begin
            rgb = WATER;
        end
    end

    // Motion and reload never overlap
    a_run_restart : assert property (@(posedge clk) disable iff (!arst_n)
        !(run && restart));

endmodule

// File: design/river_top.sv
module river_top (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                bright,
    input  river_video_pkg::scan_t              scan,
    input  logic                                tick,
    input  logic                                btn_left,
    input  logic                                btn_right,
    input  logic                                btn_center,
    output river_video_pkg::rgb_t               rgb,
    output logic [river_geom_pkg::SCORE_W-1:0]  score,
    output logic                                game_over
);
    import river_video_pkg::*;

    // Controls from the game FSM
    logic   run;
    logic   restart;

    // Per-pixel coverage from the two moving parts
    layer_t boat_layer;
    layer_t rock_layer;

    boat_steer u_boat (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .restart    (restart),
        .tick       (tick),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .scan       (scan),
        .boat_layer (boat_layer)
    );

    rock_field u_rocks (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .restart    (restart),
        .tick       (tick),
        .scan       (scan),
        .rock_layer (rock_layer),
        .score      (score)
    );

    // Collision, game state and final colour
    river_scene u_scene (
        .clk        (clk),
        .arst_n     (arst_n),
        .bright     (bright),
        .btn_center (btn_center),
        .scan       (scan),
        .boat_layer (boat_layer),
        .rock_layer (rock_layer),
        .run        (run),
        .restart    (restart),
        .game_over  (game_over),
        .rgb        (rgb)
    );

endmodule

// File: sim/river_checker.sv
module river_checker (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                tick,
    input  logic                                btn_center,
    input  river_video_pkg::rgb_t               rgb,
    input  logic [river_geom_pkg::SCORE_W-1:0]  score,
    input  logic                                game_over,
    input  logic                                exp_valid,
    input  logic [1:0]                          rgb_mode,
    input  river_video_pkg::rgb_t               exp_rgb,
    input  logic                                exp_game_over,
    input  logic                                score_chk,
    input  logic [river_geom_pkg::SCORE_W-1:0]  exp_score,
    output int                                  errors,
    output int                                  checks
);
    import river_geom_pkg::*;
    import river_video_pkg::*;

    // Colour compare modes of a table row
    localparam logic [1:0] CMP_EQ = 2'd1;
    localparam logic [1:0] CMP_NE = 2'd2;

    // Reference rock rows, lanes play no part in scoring
    coord_t               rows [ROCK_COUNT];
    logic [SCORE_W-1:0]   model_score;
    // High during the reload cycle after a centre press
    logic                 start_flag;
    int                   err_count = 0;
    int                   chk_count = 0;

    assign errors = err_count;
    assign checks = chk_count;

    always @(posedge clk or negedge arst_n) begin
        logic any_wrap;
        if (!arst_n) begin
            for (int i = 0; i < ROCK_COUNT; i++) begin
                rows[i] <= ROCK_START_Y[i];
            end
            model_score <= '0;
            start_flag  <= 1'b0;
        end else begin
            // Score against own wrap count, every cycle
            if (score !== model_score) begin
                err_count++;
                $display("Mismatch at %0t: score %0d, wrap count gives %0d",
                         $time, score, model_score);
            end
            if (exp_valid) begin
                chk_count++;
                if (rgb_mode == CMP_EQ && rgb !== exp_rgb) begin
                    err_count++;
                    $display("Mismatch at %0t: rgb %h, expected %h", $time, rgb, exp_rgb);
                end
                if (rgb_mode == CMP_NE && rgb === exp_rgb) begin
                    err_count++;
                    $display("Mismatch at %0t: rgb %h, expected anything else", $time, rgb);
                end
                if (game_over !== exp_game_over) begin
                    err_count++;
                    $display("Mismatch at %0t: game_over %b, expected %b",
                             $time, game_over, exp_game_over);
                end
                if (score_chk && score !== exp_score) begin
                    err_count++;
                    $display("Mismatch at %0t: score %0d, table expects %0d",
                             $time, score, exp_score);
                end
            end
            // Next state of the reference
            if (start_flag) begin
                for (int i = 0; i < ROCK_COUNT; i++) begin
                    rows[i] <= ROCK_START_Y[i];
                end
                model_score <= '0;
                start_flag  <= 1'b0;
            end else begin
                any_wrap = 1'b0;
                if (!game_over && tick) begin
                    for (int i = 0; i < ROCK_COUNT; i++) begin
                        if (rows[i] >= ROCK_WRAP_Y) begin
                            rows[i]  <= '0;
                            any_wrap = 1'b1;
                        end else begin
                            rows[i] <= rows[i] + ROCK_STEP;
                        end
                    end
                end
                model_score <= model_score + SCORE_W'(any_wrap);
                start_flag  <= btn_center;
            end
        end
    end

endmodule

// File: sim/river_tb.sv
module river_tb;
    import river_geom_pkg::*;
    import river_video_pkg::*;

    localparam logic [1:0] CMP_NONE = 2'd0;
    localparam logic [1:0] CMP_EQ   = 2'd1;
    localparam logic [1:0] CMP_NE   = 2'd2;
    localparam int NUM_STEPS = 21;

    // One table row
    // Buttons ordered left, right, center
    typedef struct packed {
        logic [2:0]  btns;
        logic [15:0] ticks;
        logic        on_point;
        coord_t      h;
        coord_t      v;
        logic        bright;
        logic [1:0]  mode;
        rgb_t        exp_rgb;
        logic        exp_go;
        logic        score_chk;
        logic [15:0] exp_score;
    } step_t;

    logic clk;
    logic arst_n;
    logic bright;
    scan_t scan;
    logic tick;
    logic btn_left;
    logic btn_right;
    logic btn_center;
    rgb_t rgb;
    logic [SCORE_W-1:0] score;
    logic game_over;

    // Expectations handed to the checker
    logic exp_valid;
    logic [1:0] rgb_mode;
    rgb_t exp_rgb;
    logic exp_game_over;
    logic score_chk;
    logic [SCORE_W-1:0] exp_score;
    int errors;
    int checks;

    step_t steps [NUM_STEPS];
    int limit = 0;
    int cycles = 0;

    river_top u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .bright     (bright),
        .scan       (scan),
        .tick       (tick),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .btn_center (btn_center),
        .rgb        (rgb),
        .score      (score),
        .game_over  (game_over)
    );

    river_checker u_check (
        .clk           (clk),
        .arst_n        (arst_n),
        .tick          (tick),
        .btn_center    (btn_center),
        .rgb           (rgb),
        .score         (score),
        .game_over     (game_over),
        .exp_valid     (exp_valid),
        .rgb_mode      (rgb_mode),
        .exp_rgb       (exp_rgb),
        .exp_game_over (exp_game_over),
        .score_chk     (score_chk),
        .exp_score     (exp_score),
        .errors        (errors),
        .checks        (checks)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Cycle limit from the table length
    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: run went past %0d cycles", limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic step_t make_step(logic [2:0] btns, int ticks, logic on_point,
                                        int h, int v, logic bright_lvl, logic [1:0] mode,
                                        rgb_t exp_col, logic exp_go, logic chk, int exp_sc);
        step_t s;
        s.btns      = btns;
        s.ticks     = 16'(ticks);
        s.on_point  = on_point;
        s.h         = coord_t'(h);
        s.v         = coord_t'(v);
        s.bright    = bright_lvl;
        s.mode      = mode;
        s.exp_rgb   = exp_col;
        s.exp_go    = exp_go;
        s.score_chk = chk;
        s.exp_score = 16'(exp_sc);
        return s;
    endfunction

    // Random point in a sand column that boat and rock never reach
    function automatic scan_t sand_point();
        scan_t p;
        if ($urandom % 2 == 0) begin
            p.h = coord_t'($urandom % 284);
        end else begin
            p.h = coord_t'(644 + $urandom % 156);
        end
        p.v = coord_t'($urandom % 525);
        return p;
    endfunction

    task automatic apply_step(input step_t s);
        // Press for one cycle while scanning sand
        @(negedge clk);
        scan = sand_point();
        {btn_left, btn_right, btn_center} = s.btns;
        @(negedge clk);
        {btn_left, btn_right, btn_center} = 3'b000;
        // One tick every 4 clocks
        for (int k = 0; k < s.ticks; k++) begin
            tick = 1'b1;
            if (s.on_point) begin
                scan.h = s.h;
                scan.v = s.v;
            end else begin
                scan = sand_point();
            end
            @(negedge clk);
            tick = 1'b0;
            repeat (3) @(negedge clk);
        end
        scan.h = s.h;
        scan.v = s.v;
        bright = s.bright;
        @(negedge clk);
        rgb_mode      = s.mode;
        exp_rgb       = s.exp_rgb;
        exp_game_over = s.exp_go;
        score_chk     = s.score_chk;
        exp_score     = s.exp_score;
        exp_valid     = 1'b1;
        @(negedge clk);
        exp_valid = 1'b0;
        bright    = 1'b1;
    endtask

    initial begin
        int total_ticks;
        void'($urandom(32'hafe3_1256));
        arst_n = 1'b0;
        bright = 1'b1;
        scan = '0;
        tick = 1'b0;
        btn_left = 1'b0;
        btn_right = 1'b0;
        btn_center = 1'b0;
        exp_valid = 1'b0;
        rgb_mode = CMP_NONE;
        exp_rgb = BLACK;
        exp_game_over = 1'b0;
        score_chk = 1'b0;
        exp_score = '0;

        // Reset picture
        steps[0]  = make_step(3'b000, 0, 0, 200, 100, 1, CMP_EQ, SAND, 0, 1, 0);
        steps[1]  = make_step(3'b000, 0, 0, 464, 440, 1, CMP_EQ, BOAT_WHITE, 0, 1, 0);
        steps[2]  = make_step(3'b000, 0, 0, 394, 10, 1, CMP_EQ, WATER, 0, 1, 0);
        steps[3]  = make_step(3'b000, 0, 0, 464, 440, 0, CMP_EQ, BLACK, 0, 1, 0);
        // Scoring with first wraps at ticks 51, 81, 111 and 141
        steps[4]  = make_step(3'b000, 50, 0, 200, 100, 1, CMP_EQ, SAND, 0, 1, 0);
        steps[5]  = make_step(3'b000, 1, 0, 200, 100, 1, CMP_EQ, SAND, 0, 1, 1);
        steps[6]  = make_step(3'b000, 90, 0, 200, 100, 1, CMP_EQ, SAND, 0, 1, 4);
        // Steering right and then left twice
        steps[7]  = make_step(3'b010, 28, 0, 604, 440, 1, CMP_EQ, BOAT_WHITE, 0, 0, 0);
        steps[8]  = make_step(3'b000, 0, 0, 464, 440, 1, CMP_NE, BOAT_WHITE, 0, 0, 0);
        steps[9]  = make_step(3'b010, 28, 0, 604, 440, 1, CMP_EQ, BOAT_WHITE, 0, 0, 0);
        steps[10] = make_step(3'b100, 28, 0, 464, 440, 1, CMP_EQ, BOAT_WHITE, 0, 0, 0);
        steps[11] = make_step(3'b100, 28, 0, 324, 440, 1, CMP_EQ, BOAT_WHITE, 0, 0, 0);
        steps[12] = make_step(3'b000, 0, 0, 604, 440, 1, CMP_NE, BOAT_WHITE, 0, 0, 0);
        // Restart and let rock 2 meet the boat on tick 25
        steps[13] = make_step(3'b001, 0, 0, 200, 100, 1, CMP_EQ, SAND, 0, 1, 0);
        steps[14] = make_step(3'b000, 24, 1, 464, 400, 1, CMP_EQ, BOAT_WHITE, 0, 1, 0);
        steps[15] = make_step(3'b000, 1, 1, 464, 400, 1, CMP_EQ, HIT_RED, 1, 1, 0);
        steps[16] = make_step(3'b000, 20, 1, 464, 400, 1, CMP_EQ, HIT_RED, 1, 1, 0);
        // Restart out of game over
        steps[17] = make_step(3'b001, 0, 0, 200, 100, 1, CMP_EQ, SAND, 0, 1, 0);
        steps[18] = make_step(3'b000, 0, 0, 464, 440, 1, CMP_EQ, BOAT_WHITE, 0, 1, 0);
        steps[19] = make_step(3'b000, 0, 0, 394, 10, 1, CMP_EQ, WATER, 0, 1, 0);
        steps[20] = make_step(3'b000, 0, 0, 200, 100, 0, CMP_EQ, BLACK, 0, 1, 0);

        total_ticks = 0;
        for (int i = 0; i < NUM_STEPS; i++) begin
            total_ticks += int'(steps[i].ticks);
        end
        limit = total_ticks * 4 + 200;

        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < NUM_STEPS; i++) begin
            apply_step(steps[i]);
        end
        repeat (2) @(negedge clk);

        $display("Row checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: river.f
design/river_geom_pkg.sv
design/river_video_pkg.sv
design/boat_steer.sv
design/rock_field.sv
design/river_scene.sv
design/river_top.sv
sim/river_checker.sv
sim/river_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module river_tb -f river.f -o river_sim \
    && ./obj_dir/river_sim | tee sim.log \
    || { echo "Build or run error"; exit 1; }
grep -qF '*** PASSED ***' sim.log && exit 0 || exit 1
